// ==== tb.f ====
design/rob_pkg.sv
design/lane_wr_if.sv
design/rob_pointers.sv
design/wb_lane.sv
design/rob_entries.sv
design/commit_unit.sv
design/rob_top.sv
bench/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module rob_tb -f tb.f -o Vrob_tb

# The log decides the result
./obj_dir/Vrob_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== bench/rob_tb.sv ====
// =====================================================================
// Vector reorder buffer testbench
// Random group allocation, out-of-order results on three ports and
// in-order commit, checked against a slot model of the buffer
// =====================================================================
`default_nettype none

module rob_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rob_pkg::*;

  localparam int NUM_INSTR   = 200;
  localparam int CYC_PER_INS = 40;
  localparam int RST_CYCLES  = 8;
  localparam int FLUSH_EVERY = 70;

  logic                   CLK;
  logic                   nRST;
  logic                   alloc_ena;
  lmul_t                  lmul;
  logic                   full;
  idx_t                   cur_tail;
  logic                   res_ready     [NUM_PORTS];
  idx_t                   res_index     [NUM_PORTS];
  vreg_t                  res_vd        [NUM_PORTS];
  elem_t                  res_woffset   [NUM_PORTS];
  elem_t                  res_vl        [NUM_PORTS];
  sew_t                   res_sew       [NUM_PORTS];
  logic [RES_BITS-1:0]    res_wdata     [NUM_PORTS];
  logic [1:0]             res_wen       [NUM_PORTS];
  logic                   res_exception [NUM_PORTS];
  logic [3:0]             res_exc_index [NUM_PORTS];
  logic                   commit_ena;
  logic                   flush;
  logic                   vreg_wen;
  logic                   commit_done;
  logic                   v_exception;
  vreg_t                  vd_final;
  logic [ENTRY_BITS-1:0]  wdata_final;
  logic [ENTRY_BYTES-1:0] byte_ena;

  // Slot model of the buffer, indexed by entry number
  logic [ENTRY_BITS-1:0]  m_data   [NUM_ENTRY];
  logic [ENTRY_BYTES-1:0] m_be     [NUM_ENTRY];
  vreg_t                  m_vd     [NUM_ENTRY];
  logic                   m_filled [NUM_ENTRY];
  logic                   m_final  [NUM_ENTRY];
  logic                   m_exc    [NUM_ENTRY];
  int                     m_exci   [NUM_ENTRY];
  int                     m_bpe    [NUM_ENTRY];
  int                     m_head;
  int                     m_count;

  // Instruction bound to each result port
  logic  p_busy [NUM_PORTS];
  int    p_base [NUM_PORTS];
  vreg_t p_vd   [NUM_PORTS];
  sew_t  p_sew  [NUM_PORTS];
  int    p_vl   [NUM_PORTS];
  int    p_w    [NUM_PORTS];

  int    seed;
  int    issued;
  int    next_flush;
  int    pend_port;
  lmul_t pend_lmul;
  sew_t  pend_sew;
  vreg_t pend_vd;
  logic  after_clear;
  logic  was_clear;

  rob_top dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic int elems_per_entry(input sew_t s);
    case (s)
      SEW8:    return 16;
      SEW16:   return 8;
      default: return 4;
    endcase
  endfunction

  function automatic int group_len(input lmul_t l);
    case (l)
      LMUL1:   return 1;
      LMUL2:   return 2;
      default: return 4;
    endcase
  endfunction

  function automatic logic any_port_busy();
    logic busy;
    busy = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      busy = busy | p_busy[q];
    end
    return busy;
  endfunction

  task automatic report_error(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic clear_slot(input int s);
    m_data[s]   = '0;
    m_be[s]     = '0;
    m_vd[s]     = '0;
    m_filled[s] = 1'b0;
    m_final[s]  = 1'b0;
    m_exc[s]    = 1'b0;
    m_exci[s]   = 0;
    m_bpe[s]    = 1;
  endtask

  task automatic clear_model();
    for (int s = 0; s < NUM_ENTRY; s++) begin
      clear_slot(s);
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      p_busy[q] = 1'b0;
    end
    m_head  = 0;
    m_count = 0;
  endtask

  task automatic drive_beat(input int p);
    int e;
    e = elems_per_entry(p_sew[p]);
    res_ready[p]   = 1'b1;
    res_index[p]   = idx_t'(p_base[p]);
    res_vd[p]      = p_vd[p];
    res_woffset[p] = elem_t'(p_w[p]);
    res_vl[p]      = elem_t'(p_vl[p]);
    res_sew[p]     = p_sew[p];
    res_wdata[p]   = {$random(seed), $random(seed)};
    res_wen[p]     = 2'($random(seed));
    // Rare fault on one element of the pair
    if (($random(seed) & 15) == 0) begin
      res_exception[p] = 1'b1;
      res_exc_index[p] = 4'((p_w[p] % e) + ($random(seed) & 1));
    end
  endtask

  // Element w at byte (w mod E)*B of entry base + w/E, element w+1 next
  task automatic write_beat(input int p);
    int e;
    int b;
    int slot;
    int pos;
    e    = elems_per_entry(p_sew[p]);
    b    = ENTRY_BYTES / e;
    slot = (p_base[p] + p_w[p] / e) % NUM_ENTRY;
    pos  = p_w[p] % e;
    for (int k = 0; k < 2; k++) begin
      for (int j = 0; j < b; j++) begin
        if (res_wen[p][k]) begin
          m_data[slot][((pos + k) * b + j) * 8 +: 8] = res_wdata[p][32 * k + 8 * j +: 8];
          m_be[slot][(pos + k) * b + j] = 1'b1;
        end
      end
    end
    if (res_exception[p] && !m_exc[slot]) begin
      m_exc[slot]  = 1'b1;
      m_exci[slot] = int'(res_exc_index[p]);
    end
    if (pos == e - 2) begin
      m_filled[slot] = 1'b1;
    end
    p_w[p] = p_w[p] + 2;
    if (p_w[p] >= p_vl[p]) begin
      p_busy[p] = 1'b0;
    end
  endtask

  // =====================================================================
  // Stimulus, checks and model update for one cycle
  // =====================================================================

  task automatic drive_inputs();
    int start;
    int p;
    alloc_ena   = 1'b0;
    flush       = 1'b0;
    commit_ena  = after_clear || (($random(seed) & 3) != 0);
    was_clear   = after_clear;
    after_clear = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      res_ready[q]     = 1'b0;
      res_exception[q] = 1'b0;
    end
    if (issued >= next_flush) begin
      // Clear the buffer in the middle of traffic
      flush       = 1'b1;
      next_flush  = next_flush + FLUSH_EVERY;
      after_clear = 1'b1;
    end else begin
      if (pend_port < 0 && issued < NUM_INSTR) begin
        start = $unsigned($random(seed)) % NUM_PORTS;
        for (int q = 0; q < NUM_PORTS; q++) begin
          p = (start + q) % NUM_PORTS;
          if (pend_port < 0 && !p_busy[p]) begin
            pend_port = p;
          end
        end
        if (pend_port >= 0) begin
          pend_lmul = lmul_t'(2'($unsigned($random(seed)) % 3));
          pend_sew  = sew_t'(2'($unsigned($random(seed)) % 3));
          pend_vd   = vreg_t'($random(seed));
        end
      end
      if (pend_port >= 0) begin
        lmul      = pend_lmul;
        alloc_ena = ($random(seed) & 1) != 0;
      end
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (p_busy[q] && (($random(seed) & 1) != 0)) begin
          drive_beat(q);
        end
      end
    end
  endtask

  task automatic check_outputs();
    logic                   exp_wen;
    logic                   exp_exc;
    logic [ENTRY_BYTES-1:0] exp_be;
    int                     tail;
    exp_wen = m_filled[m_head] && commit_ena;
    exp_exc = m_exc[m_head] && commit_ena;
    tail    = (m_head + m_count) % NUM_ENTRY;
    exp_be  = m_be[m_head];
    if (exp_exc) begin
      for (int j = 0; j < ENTRY_BYTES; j++) begin
        if (j >= m_exci[m_head] * m_bpe[m_head]) begin
          exp_be[j] = 1'b0;
        end
      end
    end
    assert (cur_tail == idx_t'(tail))
      else report_error($sformatf("cur_tail %0d, expected %0d", cur_tail, tail));
    assert (full == (NUM_ENTRY - m_count < group_len(lmul)))
      else report_error($sformatf("full %0b with %0d entries in use", full, m_count));
    assert (vreg_wen == exp_wen)
      else report_error($sformatf("vreg_wen %0b, expected %0b", vreg_wen, exp_wen));
    assert (v_exception == exp_exc)
      else report_error($sformatf("v_exception %0b, expected %0b", v_exception, exp_exc));
    assert (commit_done == (exp_wen && m_final[m_head]))
      else report_error($sformatf("commit_done %0b at entry %0d", commit_done, m_head));
    if (exp_wen) begin
      assert (vd_final == m_vd[m_head])
        else report_error($sformatf("vd_final %0d, expected %0d", vd_final, m_vd[m_head]));
      assert (wdata_final == m_data[m_head])
        else report_error($sformatf("wdata_final %h, expected %h", wdata_final,
                                    m_data[m_head]));
      assert (byte_ena == exp_be)
        else report_error($sformatf("byte_ena %h, expected %h", byte_ena, exp_be));
    end
    // Right after reset or flush the buffer must look empty
    if (was_clear) begin
      assert (!vreg_wen && cur_tail == '0 && !full)
        else report_error("buffer not empty after reset or flush");
    end
  endtask

  task automatic advance_model();
    logic accept;
    int   g;
    int   e;
    int   tail;
    int   slot;
    if (flush) begin
      clear_model();
    end else begin
      g      = group_len(lmul);
      accept = alloc_ena && (NUM_ENTRY - m_count >= g);
      if (m_filled[m_head] && commit_ena) begin
        clear_slot(m_head);
        m_head  = (m_head + 1) % NUM_ENTRY;
        m_count = m_count - 1;
      end
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (res_ready[q]) begin
          write_beat(q);
        end
      end
      if (accept) begin
        tail = (m_head + m_count) % NUM_ENTRY;
        e    = elems_per_entry(pend_sew);
        for (int k = 0; k < g; k++) begin
          slot          = (tail + k) % NUM_ENTRY;
          m_vd[slot]    = pend_vd + vreg_t'(k);
          m_final[slot] = (k == g - 1);
          m_bpe[slot]   = ENTRY_BYTES / e;
        end
        m_count           = m_count + g;
        p_busy[pend_port] = 1'b1;
        p_base[pend_port] = tail;
        p_vd[pend_port]   = pend_vd;
        p_sew[pend_port]  = pend_sew;
        p_vl[pend_port]   = g * e;
        p_w[pend_port]    = 0;
        pend_port         = -1;
        issued            = issued + 1;
      end
    end
  endtask

  initial begin
    seed        = 11581;
    issued      = 0;
    next_flush  = FLUSH_EVERY;
    pend_port   = -1;
    pend_lmul   = LMUL1;
    pend_sew    = SEW8;
    pend_vd     = '0;
    after_clear = 1'b1;
    was_clear   = 1'b0;
    nRST        = 1'b0;
    alloc_ena   = 1'b0;
    lmul        = LMUL1;
    commit_ena  = 1'b0;
    flush       = 1'b0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      res_ready[q]     = 1'b0;
      res_index[q]     = '0;
      res_vd[q]        = '0;
      res_woffset[q]   = '0;
      res_vl[q]        = '0;
      res_sew[q]       = SEW8;
      res_wdata[q]     = '0;
      res_wen[q]       = '0;
      res_exception[q] = 1'b0;
      res_exc_index[q] = '0;
    end
    clear_model();
    repeat (RST_CYCLES) @(posedge CLK);
    #2 nRST = 1'b1;
    while (issued < NUM_INSTR || m_count != 0 || pend_port >= 0 || any_port_busy()) begin
      @(posedge CLK);
      #2;
      drive_inputs();
      #8;
      check_outputs();
      advance_model();
    end
    $display("All tests passed");
    $finish;
  end

  // Watchdog sized from the instruction count
  initial begin
    repeat (RST_CYCLES + NUM_INSTR * CYC_PER_INS) @(posedge CLK);
    $display("Timeout: the run did not finish, %0d instructions issued", issued);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== design/rob_top.sv ====
// =====================================================================
// Vector reorder buffer
// Allocates entry groups per instruction, packs out-of-order results
// from three ports and commits entries in order to the register file
// =====================================================================
`default_nettype none

module rob_top (
  input  wire                              CLK,
  input  wire                              nRST,
  // Allocation
  input  wire                              alloc_ena,
  input  wire rob_pkg::lmul_t              lmul,
  output logic                             full,
  output rob_pkg::idx_t                    cur_tail,
  // Result ports
  input  wire                              res_ready     [rob_pkg::NUM_PORTS],
  input  wire rob_pkg::idx_t               res_index     [rob_pkg::NUM_PORTS],
  input  wire rob_pkg::vreg_t              res_vd        [rob_pkg::NUM_PORTS],
  input  wire rob_pkg::elem_t              res_woffset   [rob_pkg::NUM_PORTS],
  input  wire rob_pkg::elem_t              res_vl        [rob_pkg::NUM_PORTS],
  input  wire rob_pkg::sew_t               res_sew       [rob_pkg::NUM_PORTS],
  input  wire [rob_pkg::RES_BITS-1:0]      res_wdata     [rob_pkg::NUM_PORTS],
  input  wire [1:0]                        res_wen       [rob_pkg::NUM_PORTS],
  input  wire                              res_exception [rob_pkg::NUM_PORTS],
  input  wire [3:0]                        res_exc_index [rob_pkg::NUM_PORTS],
  // Commit and flush
  input  wire                              commit_ena,
  input  wire                              flush,
  output logic                             vreg_wen,
  output logic                             commit_done,
  output logic                             v_exception,
  output rob_pkg::vreg_t                   vd_final,
  output logic [rob_pkg::ENTRY_BITS-1:0]   wdata_final,
  output logic [rob_pkg::ENTRY_BYTES-1:0]  byte_ena
);
  import rob_pkg::*;

  idx_t       head;
  rob_entry_t head_entry;

  lane_wr_if lane_wr [NUM_PORTS] ();

  rob_pointers u_pointers (
    .CLK      (CLK),
    .nRST     (nRST),
    .alloc_ena(alloc_ena),
    .lmul     (lmul),
    .flush    (flush),
    .commit   (vreg_wen),
    .full     (full),
    .cur_tail (cur_tail),
    .head     (head)
  );

  // One writeback lane per result port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane
    wb_lane u_lane (
      .res_ready    (res_ready[p]),
      .res_index    (res_index[p]),
      .res_vd       (res_vd[p]),
      .res_woffset  (res_woffset[p]),
      .res_vl       (res_vl[p]),
      .res_sew      (res_sew[p]),
      .res_wdata    (res_wdata[p]),
      .res_wen      (res_wen[p]),
      .res_exception(res_exception[p]),
      .res_exc_index(res_exc_index[p]),
      .wr           (lane_wr[p])
    );
  end

  rob_entries u_entries (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .commit    (vreg_wen),
    .head      (head),
    .lanes     (lane_wr),
    .head_entry(head_entry)
  );

  commit_unit u_commit (
    .head_entry (head_entry),
    .commit_ena (commit_ena),
    .vreg_wen   (vreg_wen),
    .commit_done(commit_done),
    .v_exception(v_exception),
    .vd_final   (vd_final),
    .wdata_final(wdata_final),
    .byte_ena   (byte_ena)
  );

endmodule

`default_nettype wire

// ==== design/commit_unit.sv ====
// =====================================================================
// Commit unit
// Turns the head entry into a vector register file write, masking
// the bytes at and above a faulting element
// =====================================================================
`default_nettype none

module commit_unit (
  input  wire rob_pkg::rob_entry_t         head_entry,
  input  wire                              commit_ena,
  output logic                             vreg_wen,
  output logic                             commit_done,
  output logic                             v_exception,
  output rob_pkg::vreg_t                   vd_final,
  output logic [rob_pkg::ENTRY_BITS-1:0]   wdata_final,
  output logic [rob_pkg::ENTRY_BYTES-1:0]  byte_ena
);
  import rob_pkg::*;

  logic [3:0]             exc_byte;
  logic [ENTRY_BYTES-1:0] keep_mask;

  // Faulting element index scaled to a byte offset
  always_comb begin
    case (head_entry.sew)
      SEW32:   exc_byte = {head_entry.exc_index[1:0], 2'b00};
      SEW16:   exc_byte = {head_entry.exc_index[2:0], 1'b0};
      default: exc_byte = head_entry.exc_index;
    endcase
  end

  assign keep_mask = ~({ENTRY_BYTES{1'b1}} << exc_byte);

  assign vreg_wen    = head_entry.valid & commit_ena;
  assign commit_done = vreg_wen & head_entry.last;
  assign v_exception = head_entry.exception & commit_ena;
  assign vd_final    = head_entry.vd;
  assign wdata_final = head_entry.data;
  assign byte_ena    = v_exception ? (head_entry.byte_en & keep_mask)
                                   : head_entry.byte_en;

endmodule

`default_nettype wire

// ==== design/rob_entries.sv ====
// =====================================================================
// Reorder buffer entry store
// Merges lane writes byte by byte, keeps the first exception, clears
// the head entry on commit and the whole array on flush
// =====================================================================
`default_nettype none

module rob_entries (
  input  wire                CLK,
  input  wire                nRST,
  input  wire                flush,
  input  wire                commit,
  input  wire rob_pkg::idx_t head,
  lane_wr_if.store           lanes [rob_pkg::NUM_PORTS],
  output rob_pkg::rob_entry_t head_entry
);
  import rob_pkg::*;

  rob_entry_t mem      [NUM_ENTRY];
  rob_entry_t next_mem [NUM_ENTRY];

  logic                   w_wr        [NUM_PORTS];
  idx_t                   w_index     [NUM_PORTS];
  vreg_t                  w_vd        [NUM_PORTS];
  logic [ENTRY_BITS-1:0]  w_data      [NUM_PORTS];
  logic [ENTRY_BYTES-1:0] w_be        [NUM_PORTS];
  logic                   w_set_valid [NUM_PORTS];
  logic                   w_last      [NUM_PORTS];
  logic                   w_exc       [NUM_PORTS];
  logic [3:0]             w_exc_index [NUM_PORTS];
  sew_t                   w_sew       [NUM_PORTS];

  // Per-port view of the lane writes
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_unpack
    assign w_wr[p]        = lanes[p].wr;
    assign w_index[p]     = lanes[p].index;
    assign w_vd[p]        = lanes[p].vd;
    assign w_data[p]      = lanes[p].data_shifted;
    assign w_be[p]        = lanes[p].byte_en_shifted;
    assign w_set_valid[p] = lanes[p].set_valid;
    assign w_last[p]      = lanes[p].last;
    assign w_exc[p]       = lanes[p].exception;
    assign w_exc_index[p] = lanes[p].exc_index;
    assign w_sew[p]       = lanes[p].sew;
  end

  always_comb begin
    next_mem = mem;
    if (commit) begin
      next_mem[head] = '0;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (w_wr[p]) begin
        next_mem[w_index[p]].vd        = w_vd[p];
        next_mem[w_index[p]].sew       = w_sew[p];
        next_mem[w_index[p]].valid     = next_mem[w_index[p]].valid | w_set_valid[p];
        next_mem[w_index[p]].last      = next_mem[w_index[p]].last | w_last[p];
        // Enabled bytes build up over the beats of one instruction
        next_mem[w_index[p]].byte_en   = next_mem[w_index[p]].byte_en | w_be[p];
        if (w_exc[p] && !next_mem[w_index[p]].exception) begin
          next_mem[w_index[p]].exc_index = w_exc_index[p];
        end
        next_mem[w_index[p]].exception = next_mem[w_index[p]].exception | w_exc[p];
        for (int b = 0; b < ENTRY_BYTES; b++) begin
          if (w_be[p][b]) begin
            next_mem[w_index[p]].data[8*b +: 8] = w_data[p][8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        mem[i] <= '0;
      end
    end else if (flush) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        mem[i] <= '0;
      end
    end else begin
      mem <= next_mem;
    end
  end

  assign head_entry = mem[head];

  // =====================================================================
  // Checks
  // =====================================================================

  // Each entry belongs to one instruction, bound to one port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk_a
    for (genvar q = p + 1; q < NUM_PORTS; q++) begin : g_chk_b
      a_no_index_clash : assert property (
        @(posedge CLK) disable iff (!nRST)
        !(w_wr[p] && w_wr[q] && (w_index[p] == w_index[q]))
      ) else $error("rob_entries: lanes %0d and %0d hit one entry", p, q);
    end
  end

endmodule

`default_nettype wire

// ==== design/wb_lane.sv ====
// =====================================================================
// Writeback lane
// Packs one result port's element pair into an entry-sized write,
// picking the target entry and register from the element offset
// =====================================================================
`default_nettype none

module wb_lane (
  input  wire                               res_ready,
  input  wire rob_pkg::idx_t                res_index,
  input  wire rob_pkg::vreg_t               res_vd,
  input  wire rob_pkg::elem_t               res_woffset,
  input  wire rob_pkg::elem_t               res_vl,
  input  wire rob_pkg::sew_t                res_sew,
  input  wire [rob_pkg::RES_BITS-1:0]       res_wdata,
  input  wire [1:0]                         res_wen,
  input  wire                               res_exception,
  input  wire [3:0]                         res_exc_index,
  lane_wr_if.lane                           wr
);
  import rob_pkg::*;

  logic [2:0]          e_shift;
  logic [1:0]          b_shift;
  elem_t               e_mask;
  elem_t               ent_off;
  elem_t               e_pos;
  logic [3:0]          byte_pos;
  logic [7:0]          w_plus2;
  logic                reached_end;
  logic [RES_BITS-1:0] pair_data;
  logic [7:0]          pair_be;

  assign e_shift = elem_shift(res_sew);
  assign b_shift = byte_shift(res_sew);

  // Entry within the group, and element slot within that entry
  assign e_mask   = (elem_t'(1) << e_shift) - elem_t'(1);
  assign ent_off  = res_woffset >> e_shift;
  assign e_pos    = res_woffset & e_mask;
  assign byte_pos = 4'(e_pos << b_shift);

  // Pair reaches the end of the instruction when w >= vl-2
  assign w_plus2     = {1'b0, res_woffset} + 8'd2;
  assign reached_end = (w_plus2 >= {1'b0, res_vl});

  // Element 0 in the low word, element 1 in the high word
  always_comb begin
    pair_data = '0;
    pair_be   = '0;
    case (res_sew)
      SEW32: begin
        pair_data = res_wdata;
        pair_be   = {{4{res_wen[1]}}, {4{res_wen[0]}}};
      end
      SEW16: begin
        pair_data[31:0] = {res_wdata[47:32], res_wdata[15:0]};
        pair_be[3:0]    = {{2{res_wen[1]}}, {2{res_wen[0]}}};
      end
      default: begin
        pair_data[15:0] = {res_wdata[39:32], res_wdata[7:0]};
        pair_be[1:0]    = res_wen;
      end
    endcase
  end

  assign wr.wr              = res_ready;
  assign wr.index           = res_index + idx_t'(ent_off);
  assign wr.vd              = res_vd + vreg_t'(ent_off);
  assign wr.data_shifted    = ENTRY_BITS'(pair_data) << {byte_pos, 3'b000};
  assign wr.byte_en_shifted = ENTRY_BYTES'(pair_be) << byte_pos;
  assign wr.set_valid       = (e_pos == (e_mask - elem_t'(1))) | reached_end;
  assign wr.last            = reached_end;
  assign wr.exception       = res_exception;
  assign wr.exc_index       = res_exc_index;
  assign wr.sew             = res_sew;

  // Pairs are always aligned on an even element
  always_comb begin
    if (res_ready) begin
      a_even_woffset : assert final (!res_woffset[0])
        else $error("wb_lane: odd woffset %0d", res_woffset);
    end
  end

endmodule

`default_nettype wire

// ==== design/rob_pointers.sv ====
// =====================================================================
// Reorder buffer pointers
// Head and tail with wrap bits, group allocation and the full flag
// =====================================================================
`default_nettype none

module rob_pointers (
  input  wire                 CLK,
  input  wire                 nRST,
  input  wire                 alloc_ena,
  input  wire rob_pkg::lmul_t lmul,
  input  wire                 flush,
  input  wire                 commit,
  output logic                full,
  output rob_pkg::idx_t       cur_tail,
  output rob_pkg::idx_t       head
);
  import rob_pkg::*;

  ptr_t head_ptr;
  ptr_t tail_ptr;
  ptr_t occupancy;
  ptr_t free_cnt;
  ptr_t group;
  logic alloc_ok;

  // Wrap bit makes the difference exact from 0 to NUM_ENTRY
  assign occupancy = tail_ptr - head_ptr;
  assign free_cnt  = ptr_t'(NUM_ENTRY) - occupancy;
  assign group     = group_size(lmul);

  assign full     = (free_cnt < group);
  assign alloc_ok = alloc_ena & ~full;

  assign cur_tail = tail_ptr[2:0];
  assign head     = head_ptr[2:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else if (flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (commit) begin
        head_ptr <= head_ptr + ptr_t'(1);
      end
      if (alloc_ok) begin
        tail_ptr <= tail_ptr + group;
      end
    end
  end

  // =====================================================================
  // Checks
  // =====================================================================

  // A valid head entry must always lie inside the allocated window
  a_no_commit_when_empty : assert property (
    @(posedge CLK) disable iff (!nRST)
    commit |-> (occupancy != '0)
  ) else $error("rob_pointers: commit with empty buffer");

endmodule

`default_nettype wire

// ==== design/lane_wr_if.sv ====
// =====================================================================
// Lane write bundle
// One packed, entry-aligned write from a writeback lane to the store
// =====================================================================
`default_nettype none

interface lane_wr_if;
  import rob_pkg::*;

  logic                   wr;
  idx_t                   index;
  vreg_t                  vd;
  logic [ENTRY_BITS-1:0]  data_shifted;
  logic [ENTRY_BYTES-1:0] byte_en_shifted;
  logic                   set_valid;
  logic                   last;
  logic                   exception;
  logic [3:0]             exc_index;
  sew_t                   sew;

  modport lane (output wr, index, vd, data_shifted, byte_en_shifted,
                output set_valid, last, exception, exc_index, sew);

  modport store (input wr, index, vd, data_shifted, byte_en_shifted,
                 input set_valid, last, exception, exc_index, sew);

endinterface

`default_nettype wire

// ==== design/rob_pkg.sv ====
// =====================================================================
// Vector reorder buffer shared definitions
// Sizes, element width and group encodings, and the entry layout
// =====================================================================
`default_nettype none

package rob_pkg;

  localparam int NUM_ENTRY   = 8;
  localparam int NUM_PORTS   = 3;
  localparam int ENTRY_BYTES = 16;
  localparam int ENTRY_BITS  = 128;
  localparam int RES_BITS    = 64;

  typedef logic [2:0] idx_t;
  typedef logic [3:0] ptr_t;
  typedef logic [4:0] vreg_t;
  typedef logic [6:0] elem_t;

  typedef enum logic [1:0] {SEW8, SEW16, SEW32} sew_t;
  typedef enum logic [1:0] {LMUL1, LMUL2, LMUL4} lmul_t;

  typedef struct packed {
    logic [ENTRY_BITS-1:0]  data;
    vreg_t                  vd;
    logic [ENTRY_BYTES-1:0] byte_en;
    logic                   valid;
    logic                   last;
    logic                   exception;
    logic [3:0]             exc_index;
    sew_t                   sew;
  } rob_entry_t;

  // Entries taken by one instruction
  function automatic ptr_t group_size(lmul_t lmul);
    case (lmul)
      LMUL2:   return ptr_t'(2);
      LMUL4:   return ptr_t'(4);
      default: return ptr_t'(1);
    endcase
  endfunction

  // log2 of elements per entry (16, 8, 4)
  function automatic logic [2:0] elem_shift(sew_t sew);
    case (sew)
      SEW16:   return 3'd3;
      SEW32:   return 3'd2;
      default: return 3'd4;
    endcase
  endfunction

  // log2 of bytes per element (1, 2, 4)
  function automatic logic [1:0] byte_shift(sew_t sew);
    case (sew)
      SEW16:   return 2'd1;
      SEW32:   return 2'd2;
      default: return 2'd0;
    endcase
  endfunction

endpackage

`default_nettype wire
